// File: hw/core_pkg.sv
// Core package
// Widths, encodings and stage payloads
`default_nettype none

package core_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     addr_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     inst_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        addr_t     pc;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        logic      load;
        logic      store;
        logic      branch;
        logic      branch_eq;
        addr_t     branch_target;
    } decode_pkt_t;

    typedef struct packed {
        addr_t     pc;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        logic      load;
        logic      store;
    } exec_pkt_t;

    // rd is zero for instructions that write nothing
    typedef struct packed {
        addr_t     pc;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } dmem_req_t;

    typedef struct packed {
        logic      write;
        reg_addr_t rd;
        word_t     value;
    } fwd_t;

endpackage

`default_nettype wire

// File: hw/core_top.sv
// Five-stage RV32I subset core
`default_nettype none

module core_top
    import core_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  wire logic      clk,
    input  wire logic      reset_i,
    output addr_t          pc_o,
    input  wire inst_t     inst_i,
    output logic           dmem_req_valid_o,
    input  wire logic      dmem_req_ready_i,
    output dmem_req_t      dmem_req_o,
    input  wire word_t     dmem_rdata_i,
    output logic           retire_valid_o,
    output retire_t        retire_o
);

    redirect_t   redirect;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_pkt_t  fetch_pkt;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       rs1_data;
    word_t       rs2_data;
    fwd_t        fwd_ex;
    fwd_t        fwd_mem;
    logic        ex_load_pending;
    logic        decode_valid;
    logic        decode_ready;
    decode_pkt_t decode_pkt;
    logic        exec_valid;
    logic        exec_ready;
    exec_pkt_t   exec_pkt;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_o          (pc_o),
        .inst_i        (inst_i),
        .redirect_i    (redirect),
        .fetch_valid_o (fetch_valid),
        .fetch_ready_i (fetch_ready),
        .fetch_o       (fetch_pkt)
    );

    decode_stage decode_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .fetch_valid_i     (fetch_valid),
        .fetch_ready_o     (fetch_ready),
        .fetch_i           (fetch_pkt),
        .rs1_o             (rs1),
        .rs2_o             (rs2),
        .rs1_data_i        (rs1_data),
        .rs2_data_i        (rs2_data),
        .fwd_ex_i          (fwd_ex),
        .fwd_mem_i         (fwd_mem),
        .ex_load_pending_i (ex_load_pending),
        .redirect_i        (redirect),
        .decode_valid_o    (decode_valid),
        .decode_ready_i    (decode_ready),
        .decode_o          (decode_pkt)
    );

    // Writeback port is the retire port
    reg_file reg_file_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .rs1_i         (rs1),
        .rs2_i         (rs2),
        .rs1_data_o    (rs1_data),
        .rs2_data_o    (rs2_data),
        .write_valid_i (retire_valid_o),
        .write_i       (retire_o)
    );

    execute_stage execute_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .decode_valid_i (decode_valid),
        .decode_ready_o (decode_ready),
        .decode_i       (decode_pkt),
        .redirect_o     (redirect),
        .fwd_o          (fwd_ex),
        .load_pending_o (ex_load_pending),
        .exec_valid_o   (exec_valid),
        .exec_ready_i   (exec_ready),
        .exec_o         (exec_pkt)
    );

    memory_stage memory_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .exec_valid_i     (exec_valid),
        .exec_ready_o     (exec_ready),
        .exec_i           (exec_pkt),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_req_ready_i (dmem_req_ready_i),
        .dmem_req_o       (dmem_req_o),
        .dmem_rdata_i     (dmem_rdata_i),
        .fwd_o            (fwd_mem),
        .retire_valid_o   (retire_valid_o),
        .retire_o         (retire_o)
    );

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
// Decode stage
// Operand select, hazard hold and the decode-to-execute register
`default_nettype none

module decode_stage
    import core_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       fetch_valid_i,
    output logic            fetch_ready_o,
    input  wire fetch_pkt_t fetch_i,
    output reg_addr_t       rs1_o,
    output reg_addr_t       rs2_o,
    input  wire word_t      rs1_data_i,
    input  wire word_t      rs2_data_i,
    input  wire fwd_t       fwd_ex_i,
    input  wire fwd_t       fwd_mem_i,
    input  wire logic       ex_load_pending_i,
    input  wire redirect_t  redirect_i,
    output logic            decode_valid_o,
    input  wire logic       decode_ready_i,
    output decode_pkt_t     decode_o
);

    inst_t       inst;
    opcode_e     opcode;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_u;
    word_t       rs1_val;
    word_t       rs2_val;
    logic        use_rs1;
    logic        use_rs2;
    logic        opcode_ok;
    logic        hazard;
    logic        load_en;
    logic        valid_q;
    decode_pkt_t pkt_q;
    decode_pkt_t pkt_next;

    // Newest producer wins, register file covers the rest
    function automatic word_t pick(reg_addr_t src, word_t rf_data, fwd_t ex, fwd_t mem);
        if (src == '0) begin
            return '0;
        end else if (ex.write && ex.rd == src) begin
            return ex.value;
        end else if (mem.write && mem.rd == src) begin
            return mem.value;
        end
        return rf_data;
    endfunction

    // Result of the packet in our own register is not out of the ALU yet,
    // and a load in execute has no data until memory answers
    function automatic logic raw(reg_addr_t src, logic used, logic own_valid,
                                 decode_pkt_t own, logic ex_load, reg_addr_t ex_rd);
        return used && (src != '0) &&
               ((own_valid && own.reg_write && own.rd == src) ||
                (ex_load && ex_rd == src));
    endfunction

    assign inst   = fetch_i.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign rs1_o  = inst[19:15];
    assign rs2_o  = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    assign rs1_val = pick(rs1_o, rs1_data_i, fwd_ex_i, fwd_mem_i);
    assign rs2_val = pick(rs2_o, rs2_data_i, fwd_ex_i, fwd_mem_i);

    assign opcode_ok = opcode inside {OP, OP_IMM, LUI, LOAD, STORE, BRANCH};

    always_comb begin
        pkt_next               = '0;
        pkt_next.pc            = fetch_i.pc;
        pkt_next.alu_op        = ALU_ADD;
        pkt_next.op_a          = rs1_val;
        pkt_next.op_b          = imm_i;
        pkt_next.store_data    = rs2_val;
        pkt_next.rd            = inst[11:7];
        pkt_next.branch_target = fetch_i.pc + imm_b;
        use_rs1                = 1'b1;
        use_rs2                = 1'b0;
        case (opcode)
            OP: begin
                use_rs2            = 1'b1;
                pkt_next.op_b      = rs2_val;
                pkt_next.reg_write = 1'b1;
                case (inst[14:12])
                    3'b100:  pkt_next.alu_op = ALU_XOR;
                    3'b110:  pkt_next.alu_op = ALU_OR;
                    3'b111:  pkt_next.alu_op = ALU_AND;
                    default: pkt_next.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                endcase
            end
            OP_IMM: begin
                pkt_next.reg_write = 1'b1;
            end
            LUI: begin
                use_rs1            = 1'b0;
                pkt_next.alu_op    = ALU_PASS_B;
                pkt_next.op_b      = imm_u;
                pkt_next.reg_write = 1'b1;
            end
            LOAD: begin
                pkt_next.reg_write = 1'b1;
                pkt_next.load      = 1'b1;
            end
            STORE: begin
                use_rs2        = 1'b1;
                pkt_next.op_b  = imm_s;
                pkt_next.store = 1'b1;
            end
            BRANCH: begin
                use_rs2            = 1'b1;
                pkt_next.op_b      = rs2_val;
                pkt_next.branch    = 1'b1;
                pkt_next.branch_eq = (inst[14:12] == 3'b000);
            end
            default: begin
                use_rs1 = 1'b0;
            end
        endcase
    end

    assign hazard = raw(rs1_o, use_rs1, valid_q, pkt_q, ex_load_pending_i, fwd_ex_i.rd) ||
                    raw(rs2_o, use_rs2, valid_q, pkt_q, ex_load_pending_i, fwd_ex_i.rd);

    assign fetch_ready_o  = (!valid_q || decode_ready_i) && !hazard;
    assign load_en        = fetch_valid_i && fetch_ready_o && !redirect_i.taken;
    assign decode_valid_o = valid_q;
    assign decode_o       = pkt_q;

    // A redirect always drains our register, so it simply empties
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (load_en) begin
            valid_q <= 1'b1;
        end else if (decode_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            pkt_q <= pkt_next;
        end
    end

    a_known_opcode: assert property (@(posedge clk) disable iff (reset_i)
        load_en |-> opcode_ok);

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
// Execute stage
`default_nettype none

module execute_stage
    import core_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        decode_valid_i,
    output logic             decode_ready_o,
    input  wire decode_pkt_t decode_i,
    output redirect_t        redirect_o,
    output fwd_t             fwd_o,
    output logic             load_pending_o,
    output logic             exec_valid_o,
    input  wire logic        exec_ready_i,
    output exec_pkt_t        exec_o
);

    word_t     result;
    logic      taken;
    logic      xfer;
    logic      valid_q;
    exec_pkt_t pkt_q;

    always_comb begin
        case (decode_i.alu_op)
            ALU_SUB:    result = decode_i.op_a - decode_i.op_b;
            ALU_AND:    result = decode_i.op_a & decode_i.op_b;
            ALU_OR:     result = decode_i.op_a | decode_i.op_b;
            ALU_XOR:    result = decode_i.op_a ^ decode_i.op_b;
            ALU_PASS_B: result = decode_i.op_b;
            default:    result = decode_i.op_a + decode_i.op_b;
        endcase
    end

    assign taken = decode_i.branch &&
                   ((decode_i.op_a == decode_i.op_b) == decode_i.branch_eq);

    assign decode_ready_o = !valid_q || exec_ready_i;
    assign xfer           = decode_valid_i && decode_ready_o;

    // Raised only on the cycle the branch moves on
    assign redirect_o = '{taken: xfer && taken, target: decode_i.branch_target};

    // Load address is not the register value
    assign fwd_o = '{write: valid_q && pkt_q.reg_write && !pkt_q.load,
                     rd:    pkt_q.rd,
                     value: pkt_q.result};
    assign load_pending_o = valid_q && pkt_q.load;

    assign exec_valid_o = valid_q;
    assign exec_o       = pkt_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (decode_ready_o) begin
            valid_q <= decode_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            pkt_q.pc         <= decode_i.pc;
            pkt_q.result     <= result;
            pkt_q.store_data <= decode_i.store_data;
            pkt_q.rd         <= decode_i.rd;
            pkt_q.reg_write  <= decode_i.reg_write;
            pkt_q.load       <= decode_i.load;
            pkt_q.store      <= decode_i.store;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
// Fetch stage
`default_nettype none

module fetch_stage
    import core_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  wire logic      clk,
    input  wire logic      reset_i,
    output addr_t          pc_o,
    input  wire inst_t     inst_i,
    input  wire redirect_t redirect_i,
    output logic           fetch_valid_o,
    input  wire logic      fetch_ready_i,
    output fetch_pkt_t     fetch_o
);

    addr_t      pc_q;
    logic       valid_q;
    fetch_pkt_t pkt_q;
    logic       take;

    // Instruction memory answers every cycle, so only the register can block
    assign take = !valid_q || fetch_ready_i;

    assign pc_o          = pc_q;
    assign fetch_valid_o = valid_q;
    assign fetch_o       = pkt_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else if (redirect_i.taken) begin
            // Word at pc_o and the held packet are both younger than the branch
            pc_q    <= redirect_i.target;
            valid_q <= 1'b0;
        end else if (take) begin
            pc_q    <= pc_q + 32'd4;
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pkt_q <= '{pc: pc_q, inst: inst_i};
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hw/memory_stage.sv
// Memory stage and writeback register
`default_nettype none

module memory_stage
    import core_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire logic      exec_valid_i,
    output logic           exec_ready_o,
    input  wire exec_pkt_t exec_i,
    output logic           dmem_req_valid_o,
    input  wire logic      dmem_req_ready_i,
    output dmem_req_t      dmem_req_o,
    input  wire word_t     dmem_rdata_i,
    output fwd_t           fwd_o,
    output logic           retire_valid_o,
    output retire_t        retire_o
);

    logic    needs_mem;
    logic    xfer;
    logic    valid_q;
    retire_t wb_q;
    retire_t wb_next;

    assign needs_mem = exec_i.load || exec_i.store;

    assign dmem_req_valid_o = exec_valid_i && needs_mem;
    assign dmem_req_o       = '{addr:  exec_i.result,
                                wdata: exec_i.store_data,
                                write: exec_i.store};

    // Writeback always drains, only the memory handshake can hold
    assign exec_ready_o = !needs_mem || dmem_req_ready_i;
    assign xfer         = exec_valid_i && exec_ready_o;

    always_comb begin
        wb_next.pc = exec_i.pc;
        wb_next.rd = exec_i.reg_write ? exec_i.rd : '0;
        if (exec_i.load) begin
            wb_next.data = dmem_rdata_i;
        end else if (exec_i.reg_write) begin
            wb_next.data = exec_i.result;
        end else begin
            wb_next.data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            wb_q <= wb_next;
        end
    end

    assign retire_valid_o = valid_q;
    assign retire_o       = wb_q;
    assign fwd_o          = '{write: valid_q && (wb_q.rd != '0), rd: wb_q.rd, value: wb_q.data};

    // Execute holds its register while memory waits
    a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
        dmem_req_valid_o && !dmem_req_ready_i |=>
            dmem_req_valid_o && $stable(dmem_req_o));

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// Integer register file
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire reg_addr_t rs1_i,
    input  wire reg_addr_t rs2_i,
    output word_t          rs1_data_o,
    output word_t          rs2_data_o,
    input  wire logic      write_valid_i,
    input  wire retire_t   write_i
);

    word_t regs [1:31];
    logic  wr_en;

    assign wr_en = write_valid_i && (write_i.rd != '0);

    // x0 reads zero, same-cycle write bypasses the array
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (wr_en && write_i.rd == rs1_i) ? write_i.data : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (wr_en && write_i.rd == rs2_i) ? write_i.data : regs[rs2_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[write_i.rd] <= write_i.data;
        end
    end

endmodule

`default_nettype wire

// File: verif/core_tb.sv
// Core testbench
// Trace-driven program, memory models and retire checks
`default_nettype none

module core_tb
    import core_pkg::*;
();

    localparam addr_t RESET_PC  = 32'h0000_0000;
    localparam int    MEM_WORDS = 64;

    logic        clk;
    logic        reset_i;
    addr_t       pc_o;
    inst_t       inst_i;
    logic        dmem_req_valid_o;
    logic        dmem_req_ready_i;
    dmem_req_t   dmem_req_o;
    word_t       dmem_rdata_i;
    logic        retire_valid_o;
    retire_t     retire_o;

    inst_t       imem [MEM_WORDS];
    word_t       dmem [MEM_WORDS];
    retire_t     exp_retire [$];
    dmem_req_t   exp_store [$];
    int          retire_idx;
    int          store_idx;
    int          cycle;
    int          cycle_limit;
    logic [31:0] rand_state;

    core_top #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .pc_o             (pc_o),
        .inst_i           (inst_i),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_req_ready_i (dmem_req_ready_i),
        .dmem_req_o       (dmem_req_o),
        .dmem_rdata_i     (dmem_rdata_i),
        .retire_valid_o   (retire_valid_o),
        .retire_o         (retire_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error at time %0t: %s is 0x%h, expected 0x%h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic load_trace();
        integer            fd;
        integer            code;
        logic [63:0]       kind;
        logic [8*200-1:0]  rest;
        logic [31:0]       f1;
        logic [31:0]       f2;
        logic [31:0]       f3;
        retire_t           ret;
        dmem_req_t         st;
        fd = $fopen("verif/core_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the trace file verif/core_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", kind);
                if (code == 1) begin
                    case (kind)
                        "#": code = $fgets(rest, fd);
                        "I": begin
                            code = $fscanf(fd, "%h %h", f1, f2);
                            imem[f1[7:2]] = f2;
                        end
                        "D": begin
                            code = $fscanf(fd, "%h %h", f1, f2);
                            dmem[f1[7:2]] = f2;
                        end
                        "R": begin
                            code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                            ret.pc   = f1;
                            ret.rd   = f2[4:0];
                            ret.data = f3;
                            exp_retire.push_back(ret);
                        end
                        "S": begin
                            code = $fscanf(fd, "%h %h", f1, f2);
                            st.addr  = f1;
                            st.wdata = f2;
                            st.write = 1'b1;
                            exp_store.push_back(st);
                        end
                        default: abort_run("Unknown line kind in the trace file");
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_retire();
        retire_t exp;
        if (retire_valid_o) begin
            exp = exp_retire[retire_idx];
            check_value("retire_o.pc", retire_o.pc, exp.pc);
            check_value("retire_o.rd", 32'(retire_o.rd), 32'(exp.rd));
            check_value("retire_o.data", retire_o.data, exp.data);
            retire_idx++;
        end
    endtask

    // Stores land before the next posedge, load data follows the current address
    task automatic answer_dmem();
        dmem_req_t exp;
        if (dmem_req_valid_o &&
            (dmem_req_o.addr[31:8] != '0 || dmem_req_o.addr[1:0] != '0)) begin
            abort_run($sformatf("Data access to 0x%h is outside the modelled memory",
                                dmem_req_o.addr));
        end else if (dmem_req_valid_o && dmem_req_ready_i && dmem_req_o.write) begin
            if (store_idx >= exp_store.size()) begin
                abort_run("The core issued more stores than the trace lists");
            end else begin
                exp = exp_store[store_idx];
                check_value("dmem_req_o.addr", dmem_req_o.addr, exp.addr);
                check_value("dmem_req_o.wdata", dmem_req_o.wdata, exp.wdata);
                dmem[dmem_req_o.addr[7:2]] = dmem_req_o.wdata;
                store_idx++;
            end
        end
        dmem_rdata_i = dmem[dmem_req_o.addr[7:2]];
    endtask

    initial begin
        reset_i          = 1'b1;
        inst_i           = '0;
        dmem_req_ready_i = 1'b0;
        dmem_rdata_i     = '0;
        retire_idx       = 0;
        store_idx        = 0;
        cycle            = 0;
        rand_state       = 32'd79;
        // Unlisted words are nops and data tagged with their address
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {12'(i * 4), 20'h00013};
            dmem[i] = 32'hDA7A_0000 | 32'(i * 4);
        end
        load_trace();
        cycle_limit = 30 * exp_retire.size() + 100;
        if (exp_retire.size() == 0) begin
            abort_run("The trace file lists no expected retirements");
        end
    end

    always @(negedge clk) begin
        cycle            = cycle + 1;
        rand_state       = next_random(rand_state);
        dmem_req_ready_i = ((rand_state[30:16] % 100) < 60);
        inst_i           = imem[pc_o[7:2]];
        if (cycle > cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles with %0d of %0d retirements seen",
                                cycle, retire_idx, exp_retire.size()));
        end else if (reset_i) begin
            check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
            check_value("dmem_req_valid_o", 32'(dmem_req_valid_o), 32'd0);
            if (cycle == 2) begin
                check_value("pc_o", pc_o, RESET_PC);
                reset_i = 1'b0;
            end
        end else begin
            check_retire();
            answer_dmem();
            if (retire_idx == exp_retire.size()) begin
                if (store_idx == exp_store.size()) begin
                    $display("*** PASSED ***");
                    $finish;
                end else begin
                    abort_run("All retirements seen but some stores never happened");
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/core_trace.txt
# I addr inst | D addr data | R pc rd data | S addr data (all hex)
# R lines in retire order, S lines in store order
I 00000000 00C00093  # addi x1, x0, 12
I 00000004 00A00113  # addi x2, x0, 10
I 00000008 002081B3  # add  x3, x1, x2
I 0000000C 40118233  # sub  x4, x3, x1
I 00000010 0041F2B3  # and  x5, x3, x4
I 00000014 0041E333  # or   x6, x3, x4
I 00000018 0062C3B3  # xor  x7, x5, x6
I 0000001C 12345437  # lui  x8, 0x12345
I 00000020 67840413  # addi x8, x8, 0x678
I 00000024 FFF00493  # addi x9, x0, -1
I 00000028 409204B3  # sub  x9, x4, x9
I 0000002C 08002503  # lw   x10, 0x80(x0)
I 00000030 001505B3  # add  x11, x10, x1
I 00000034 08B02423  # sw   x11, 0x88(x0)
I 00000038 08802603  # lw   x12, 0x88(x0)
I 0000003C 08C02623  # sw   x12, 0x8c(x0)
I 00000040 08402683  # lw   x13, 0x84(x0)
I 00000044 00168693  # addi x13, x13, 1
I 00000048 00208463  # beq  x1, x2, +8 (not taken)
I 0000004C 01100713  # addi x14, x0, 0x11
I 00000050 00220663  # beq  x4, x2, +12 (taken)
I 00000054 7FF00713  # addi x14, x0, 0x7ff (squashed)
I 00000058 55500713  # addi x14, x0, 0x555 (squashed)
I 0000005C 00171663  # bne  x14, x1, +12 (taken)
I 00000060 12300793  # addi x15, x0, 0x123 (squashed)
I 00000064 45600713  # addi x14, x0, 0x456 (squashed)
I 00000068 00411463  # bne  x2, x4, +8 (not taken)
I 0000006C 02270793  # addi x15, x14, 0x22
I 00000070 00000063  # beq  x0, x0, 0 (end loop)
D 00000080 CAFE0011
D 00000084 00000007
R 00000000 01 0000000C
R 00000004 02 0000000A
R 00000008 03 00000016
R 0000000C 04 0000000A
R 00000010 05 00000002
R 00000014 06 0000001E
R 00000018 07 0000001C
R 0000001C 08 12345000
R 00000020 08 12345678
R 00000024 09 FFFFFFFF
R 00000028 09 0000000B
R 0000002C 0A CAFE0011
R 00000030 0B CAFE001D
R 00000034 00 00000000
R 00000038 0C CAFE001D
R 0000003C 00 00000000
R 00000040 0D 00000007
R 00000044 0D 00000008
R 00000048 00 00000000
R 0000004C 0E 00000011
R 00000050 00 00000000
R 0000005C 00 00000000
R 00000068 00 00000000
R 0000006C 0F 00000033
R 00000070 00 00000000
S 00000088 CAFE001D
S 0000008C CAFE001D

// File: verilog.f
hw/core_pkg.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_top.sv
verif/core_tb.sv
